/* verilog/aes_chain_config.svh */
`ifndef AES_CHAIN_CONFIG_SVH
`define AES_CHAIN_CONFIG_SVH

// Number of round stages between the key input and the output register
`define AES_STAGES 25

// Fixed state that feeds every stage's S-box lookups
// Also XORed onto the key before the first stage
`define AES_SEED_STATE 128'hc2f45dfa_8acd3f4d_a3dcfe8a_93cefa0a

`endif

/* verilog/aes_chain_pkg.sv */
package aes_chain_pkg;

    // Full 128-bit AES state
    // Byte 0 sits in bits 127:120, column 0 in bits 127:96
    typedef logic [127:0] state_t;

    // One column of the state, or one T-table word
    typedef logic [31:0] word_t;

    // One state byte
    typedef logic [7:0] byte_t;

endpackage

/* verilog/aes_column_if.sv */
`timescale 1ns/1ps

interface aes_column_if;
    import aes_chain_pkg::*;

    // T-table words for bytes 0..3 of one column
    // t1..t3 are already rotated into their MixColumns rows
    word_t t0;
    word_t t1;
    word_t t2;
    word_t t3;

    modport lookup (
        output t0, t1, t2, t3
    );

    modport combine (
        input t0, t1, t2, t3
    );

endinterface

/* verilog/aes_sbox.sv */
`timescale 1ns/1ps

module aes_sbox (
    input  logic                 clk,
    input  logic                 rst,
    input  aes_chain_pkg::byte_t in,
    output aes_chain_pkg::byte_t sub,
    output aes_chain_pkg::byte_t sub_x2
);
    import aes_chain_pkg::*;

    byte_t sub_comb;

    ////////////////////////////////////////
    // GF(2^8) arithmetic, AES polynomial
    ////////////////////////////////////////

    // Multiply by x, reduce by x^8+x^4+x^3+x+1
    function automatic byte_t xtime(byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t acc;
        byte_t sh;
        acc = '0;
        sh = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // Inverse as a^254, the product of a^2, a^4 ... a^128
    // Zero maps to zero, as the S-box expects
    function automatic byte_t gf_inv(byte_t a);
        byte_t sq;
        byte_t acc;
        sq = a;
        acc = 8'h01;
        for (int k = 1; k < 8; k++) begin
            sq = gf_mul(sq, sq);
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    // Affine step: XOR of four left rotations, plus 0x63
    function automatic byte_t affine(byte_t a);
        return a ^ {a[6:0], a[7]} ^ {a[5:0], a[7:6]}
                 ^ {a[4:0], a[7:5]} ^ {a[3:0], a[7:4]} ^ 8'h63;
    endfunction

    ////////////////////////////////////////
    // Substitution and output registers
    ////////////////////////////////////////

    assign sub_comb = affine(gf_inv(in));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sub    <= '0;
            sub_x2 <= '0;
        end else begin
            sub    <= sub_comb;
            sub_x2 <= xtime(sub_comb);
        end
    end

    // No byte maps onto itself, so the registered result never repeats its input
    a_no_fixed_point : assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> sub != $past(in)
    );

endmodule

/* verilog/aes_column_lookup.sv */
`timescale 1ns/1ps

module aes_column_lookup (
    input  logic                 clk,
    input  logic                 rst,
    input  aes_chain_pkg::word_t column,
    aes_column_if.lookup         words
);
    import aes_chain_pkg::*;

    byte_t sub [4];
    byte_t sub_x2 [4];

    // Unrotated T-table word per byte: {2S, S, S, 3S}
    word_t base [4];

    for (genvar j = 0; j < 4; j++) begin : g_byte
        aes_sbox sbox_i (
            .clk    (clk),
            .rst    (rst),
            .in     (column[31 - 8 * j -: 8]),
            .sub    (sub[j]),
            .sub_x2 (sub_x2[j])
        );

        // 3S is 2S xor S
        assign base[j] = {sub_x2[j], sub[j], sub[j], sub_x2[j] ^ sub[j]};
    end

    ////////////////////////////////////////
    // Row alignment
    ////////////////////////////////////////

    // Byte j is rotated right by j bytes, so its 2S lands in row j
    assign words.t0 = base[0];
    assign words.t1 = {base[1][7:0],  base[1][31:8]};
    assign words.t2 = {base[2][15:0], base[2][31:16]};
    assign words.t3 = {base[3][23:0], base[3][31:24]};

endmodule

/* verilog/aes_chain_stage.sv */
`timescale 1ns/1ps

`include "aes_chain_config.svh"

module aes_chain_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  aes_chain_pkg::state_t chain_in,
    output aes_chain_pkg::state_t chain_out
);
    import aes_chain_pkg::*;

    localparam state_t seed_state = `AES_SEED_STATE;

    word_t  seed_col [4];
    word_t  t_word [4][4];
    word_t  round_col [4];
    state_t round_val;

    aes_column_if col_if [4] ();

    ////////////////////////////////////////
    // Per-column T-table lookups
    ////////////////////////////////////////

    for (genvar c = 0; c < 4; c++) begin : g_col
        assign seed_col[c] = seed_state[127 - 32 * c -: 32];

        aes_column_lookup lookup_i (
            .clk    (clk),
            .rst    (rst),
            .column (seed_col[c]),
            .words  (col_if[c])
        );

        // t_word[column][row]
        assign t_word[c][0] = col_if[c].t0;
        assign t_word[c][1] = col_if[c].t1;
        assign t_word[c][2] = col_if[c].t2;
        assign t_word[c][3] = col_if[c].t3;
    end

    ////////////////////////////////////////
    // ShiftRows combine
    ////////////////////////////////////////

    // Output column c takes row r from input column (c + r) mod 4
    for (genvar c = 0; c < 4; c++) begin : g_mix
        assign round_col[c] = t_word[c][0]
                            ^ t_word[(c + 1) % 4][1]
                            ^ t_word[(c + 2) % 4][2]
                            ^ t_word[(c + 3) % 4][3];
    end

    assign round_val = {round_col[0], round_col[1], round_col[2], round_col[3]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            chain_out <= '0;
        end else begin
            chain_out <= chain_in ^ round_val;
        end
    end

    // Catches an undriven or X input reaching this point of the chain
    a_out_known : assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(chain_out)
    );

endmodule

/* verilog/aes_key_chain.sv */
`timescale 1ns/1ps

`include "aes_chain_config.svh"

module aes_key_chain (
    input  logic                  clk,
    input  logic                  rst,
    input  aes_chain_pkg::state_t key,
    output aes_chain_pkg::state_t out
);
    import aes_chain_pkg::*;

    localparam int     num_stages = `AES_STAGES;
    localparam state_t seed_state = `AES_SEED_STATE;

    // stage_val[0] feeds the first stage, stage_val[num_stages] is the last result
    state_t stage_val [num_stages + 1];

    ////////////////////////////////////////
    // Key whitening and stage chain
    ////////////////////////////////////////

    assign stage_val[0] = key ^ seed_state;

    for (genvar s = 0; s < num_stages; s++) begin : g_stage
        aes_chain_stage stage_i (
            .clk       (clk),
            .rst       (rst),
            .chain_in  (stage_val[s]),
            .chain_out (stage_val[s + 1])
        );
    end

    // Output register, one cycle past the last stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out <= '0;
        end else begin
            out <= stage_val[num_stages];
        end
    end

endmodule

/* dv/aes_ref_model.svh */
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

////////////////////////////////////////
// GF(2^8) helpers
////////////////////////////////////////

// Doubling with the AES reduction constant
function automatic byte_t times_x(byte_t b);
    return {b[6:0], 1'b0} ^ ({8{b[7]}} & 8'h1b);
endfunction

// Shift-and-add product, walking the bits of b from the bottom
function automatic byte_t gf_multiply(byte_t a, byte_t b);
    byte_t p;
    byte_t aa;
    byte_t bb;
    p = 8'h00;
    aa = a;
    bb = b;
    while (bb != 8'h00) begin
        if (bb[0]) begin
            p = p ^ aa;
        end
        aa = times_x(aa);
        bb = bb >> 1;
    end
    return p;
endfunction

function automatic byte_t rot_left(byte_t v, int n);
    return byte_t'((v << n) | (v >> (8 - n)));
endfunction

// Inverse found by search over all nonzero bytes, then the affine map
function automatic byte_t sbox_value(byte_t a);
    byte_t inv;
    inv = 8'h00;
    for (int b = 1; b < 256; b++) begin
        if (a != 8'h00 && gf_multiply(a, byte_t'(b)) == 8'h01) begin
            inv = byte_t'(b);
        end
    end
    return inv ^ rot_left(inv, 1) ^ rot_left(inv, 2) ^ rot_left(inv, 3)
         ^ rot_left(inv, 4) ^ 8'h63;
endfunction

////////////////////////////////////////
// Round value and expected output
////////////////////////////////////////

// MixColumns(ShiftRows(SubBytes(s))), byte index is 4 * column + row
function automatic state_t round_of_state(state_t s);
    byte_t  st [16];
    byte_t  sh [16];
    byte_t  m [4];
    state_t r;
    for (int i = 0; i < 16; i++) begin
        st[i] = sbox_value(byte_t'(s >> (120 - 8 * i)));
    end
    // Row rw moves left by rw columns
    for (int c = 0; c < 4; c++) begin
        for (int rw = 0; rw < 4; rw++) begin
            sh[4 * c + rw] = st[4 * ((c + rw) % 4) + rw];
        end
    end
    r = '0;
    for (int c = 0; c < 4; c++) begin
        for (int rw = 0; rw < 4; rw++) begin
            m[rw] = gf_multiply(8'h02, sh[4 * c + rw])
                  ^ gf_multiply(8'h03, sh[4 * c + (rw + 1) % 4])
                  ^ sh[4 * c + (rw + 2) % 4]
                  ^ sh[4 * c + (rw + 3) % 4];
        end
        r = (r << 32) | state_t'({m[0], m[1], m[2], m[3]});
    end
    return r;
endfunction

// Every stage adds the same round value, so only the parity of the count matters
function automatic state_t expected_for_key(state_t k, state_t r);
    state_t odd_part;
    odd_part = ((`AES_STAGES % 2) == 1) ? r : '0;
    return k ^ `AES_SEED_STATE ^ odd_part;
endfunction

`endif

/* dv/aes_key_chain_tb.sv */
`timescale 1ns/1ps

`include "aes_chain_config.svh"

module aes_key_chain_tb;
    import aes_chain_pkg::*;

    localparam int     latency = `AES_STAGES + 1;
    localparam int     num_tests = 5;
    localparam int     cycles_per_test = 100;
    localparam int     watchdog_cycles = num_tests * cycles_per_test + 100;
    localparam state_t seed_state = `AES_SEED_STATE;

    logic        clk;
    logic        rst;
    state_t      key;
    state_t      dut_out;
    state_t      round_value;
    logic [31:0] rng_state;
    int          pass_count;
    int          fail_count;

    `include "aes_ref_model.svh"

    aes_key_chain dut_i (
        .clk (clk),
        .rst (rst),
        .key (key),
        .out (dut_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Simulation timed out after %0d cycles before the tests finished",
                 watchdog_cycles);
        $display("** FAIL **");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // xorshift32 with shifts 13, 17, 5
    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic state_t random_key();
        state_t k;
        k = '0;
        for (int i = 0; i < 4; i++) begin
            rng_state = xorshift32(rng_state);
            k = (k << 32) | state_t'(rng_state);
        end
        return k;
    endfunction

    task automatic check_value(input state_t exp, input state_t act, input string what);
        assert (act === exp) begin
            pass_count++;
        end else begin
            $display("MISMATCH at %0t ns: %s expected %h got %h", $time, what, exp, act);
            fail_count++;
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (fail_count == fails_before) begin
            $display("Test %s passed", name);
        end else begin
            $display("Test %s failed with %0d errors", name, fail_count - fails_before);
        end
    endtask

    task automatic hold_key(input state_t k, input int cycles);
        @(negedge clk);
        key = k;
        repeat (cycles) @(negedge clk);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    // Known FIPS-197 entries
    task automatic check_model_tables();
        int fails;
        fails = fail_count;
        check_value(state_t'(8'h63), state_t'(sbox_value(8'h00)), "model sbox 00");
        check_value(state_t'(8'h7c), state_t'(sbox_value(8'h01)), "model sbox 01");
        check_value(state_t'(8'hed), state_t'(sbox_value(8'h53)), "model sbox 53");
        report_test("model_tables", fails);
    endtask

    task automatic test_zero_key();
        int fails;
        fails = fail_count;
        hold_key('0, 30);
        check_value(expected_for_key('0, round_value), dut_out, "zero key");
        report_test("zero_key", fails);
    endtask

    task automatic test_directed_keys();
        state_t keys [3];
        int     fails;
        fails = fail_count;
        keys[0] = {128{1'b1}};
        keys[1] = {8{16'h55aa}};
        keys[2] = state_t'(1) << 77;
        for (int i = 0; i < 3; i++) begin
            hold_key(keys[i], 30);
            check_value(expected_for_key(keys[i], round_value), dut_out, "directed key");
        end
        report_test("directed_keys", fails);
    endtask

    // New key on each of the first 40 cycles, output checked one latency later
    task automatic test_streaming();
        state_t sent [$];
        int     fails;
        fails = fail_count;
        for (int i = 0; i < 40 + latency; i++) begin
            @(negedge clk);
            if (i >= latency) begin
                check_value(expected_for_key(sent[i - latency], round_value), dut_out,
                            "streaming");
            end
            if (i < 40) begin
                key = random_key();
                sent.push_back(key);
            end
        end
        report_test("streaming", fails);
    endtask

    task automatic test_hold_stability();
        state_t k;
        int     fails;
        fails = fail_count;
        k = random_key();
        hold_key(k, latency);
        for (int i = 0; i < 10; i++) begin
            check_value(expected_for_key(k, round_value), dut_out, "held key");
            @(negedge clk);
        end
        report_test("hold_stability", fails);
    endtask

    task automatic test_reset_midstream();
        state_t k;
        int     fails;
        fails = fail_count;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            key = random_key();
        end
        @(negedge clk);
        rst = 1'b1;
        key = random_key();
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_value('0, dut_out, "output during reset");
            key = random_key();
        end
        k = random_key();
        key = k;
        rst = 1'b0;
        repeat (28) @(negedge clk);
        check_value(expected_for_key(k, round_value), dut_out, "key after reset");
        report_test("reset_midstream", fails);
    endtask

    initial begin
        rst = 1'b1;
        key = '0;
        rng_state = 32'd63;
        pass_count = 0;
        fail_count = 0;
        round_value = round_of_state(seed_state);
        check_model_tables();
        // Eight rising edges in reset, release on the following falling edge
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_zero_key();
        test_directed_keys();
        test_streaming();
        test_hold_stability();
        test_reset_midstream();
        $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+verilog
+incdir+dv
verilog/aes_chain_pkg.sv
verilog/aes_column_if.sv
verilog/aes_sbox.sv
verilog/aes_column_lookup.sv
verilog/aes_chain_stage.sv
verilog/aes_key_chain.sv
dv/aes_key_chain_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f flist.f \
    --top-module aes_key_chain_tb -o aes_key_chain_sim || { echo "Build failed"; exit 1; }

sim_output=$(./obj_dir/aes_key_chain_sim)
echo "$sim_output"
echo "$sim_output" | grep -qF -- '** PASS **' && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
